/* axil_split_sys.f */
+incdir+testbench
source/axil_pkg.sv
source/split_map_pkg.sv
source/outstanding_counter.sv
source/flow_reg_both.sv
source/axil_split.sv
source/axil_mem_target.sv
source/axil_split_sys.sv
testbench/tb_axil_split_sys.sv

/* Makefile */
TOOL       = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_axil_split_sys
FILELIST   = axil_split_sys.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_TEXT  = All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The simulator status is lost in the pipe, so the log decides
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/tb_axil_tasks.svh */
// ----------------------------------------------------------------------------
// Random source
// ----------------------------------------------------------------------------
logic [31:0] lfsr_state = 32'h4e631b7a;

// Galois form, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] take_bits(input int n);
  logic [31:0] value;
  value = '0;
  for (int i = 0; i < n; i++) begin
    value = {value[30:0], lfsr_state[0]};
    if (lfsr_state[0]) begin
      lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
    end else begin
      lfsr_state = lfsr_state >> 1;
    end
  end
  return value;
endfunction

function automatic logic [15:0] trunk_addr();
  logic [31:0] bits;
  bits = take_bits(8);
  return {6'b0, bits[7:0], 2'b00};
endfunction

// ----------------------------------------------------------------------------
// Reference memory model
// ----------------------------------------------------------------------------
logic [31:0] trunk_model [256];
logic [31:0] branch_model [64];

function automatic logic hits_branch(input logic [15:0] address);
  return ((address >= 16'h1000) && (address <= 16'h10ff)) ||
         ((address >= 16'h2000) && (address <= 16'h20ff));
endfunction

function automatic void model_read(input logic [15:0] address, output logic [31:0] data,
                                   output logic [1:0] resp);
  if (hits_branch(address)) begin
    data = branch_model[address[7:2]];
    resp = resp_okay;
  end else if (address < 16'h0400) begin
    data = trunk_model[address[9:2]];
    resp = resp_okay;
  end else begin
    data = '0;
    resp = resp_decerr;
  end
endfunction

// Returns the expected write response
function automatic logic [1:0] model_write(input logic [15:0] address,
                                           input logic [31:0] data, input logic [3:0] strb);
  logic [31:0] word;
  logic [1:0]  resp;
  model_read(address, word, resp);
  for (int i = 0; i < 4; i++) begin
    if (strb[i]) begin
      word[8*i +: 8] = data[8*i +: 8];
    end
  end
  if (hits_branch(address)) begin
    branch_model[address[7:2]] = word;
  end else if (resp == resp_okay) begin
    trunk_model[address[9:2]] = word;
  end
  return resp;
endfunction

// ----------------------------------------------------------------------------
// Bus transactions, entered and left on a rising edge
// ----------------------------------------------------------------------------
task automatic axi_write(input logic [15:0] address, input logic [31:0] data,
                         input logic [3:0] strb, output logic [1:0] resp);
  aw       <= '{addr: address, prot: 3'b000};
  w        <= '{data: data, strb: strb};
  aw_valid <= 1'b1;
  w_valid  <= 1'b1;
  do begin
    @(posedge clk);
  end while (!aw_ready);
  aw_valid <= 1'b0;
  w_valid  <= 1'b0;
  do begin
    @(posedge clk);
  end while (!(b_valid && b_ready));
  resp = b.resp;
endtask

task automatic axi_read(input logic [15:0] address, output logic [31:0] data,
                        output logic [1:0] resp);
  ar       <= '{addr: address, prot: 3'b000};
  ar_valid <= 1'b1;
  do begin
    @(posedge clk);
  end while (!ar_ready);
  ar_valid <= 1'b0;
  do begin
    @(posedge clk);
  end while (!(r_valid && r_ready));
  data = r.data;
  resp = r.resp;
endtask

task automatic do_write(input string test, input logic [15:0] address,
                        input logic [31:0] data, input logic [3:0] strb);
  logic [1:0] exp_resp;
  logic [1:0] got_resp;
  exp_resp = model_write(address, data, strb);
  axi_write(address, data, strb, got_resp);
  check_value({test, " bresp"}, {30'b0, exp_resp}, {30'b0, got_resp});
endtask

task automatic do_read(input string test, input logic [15:0] address);
  logic [31:0] exp_data;
  logic [31:0] got_data;
  logic [1:0]  exp_resp;
  logic [1:0]  got_resp;
  axi_read(address, got_data, got_resp);
  model_read(address, exp_data, exp_resp);
  check_value({test, " rdata"}, exp_data, got_data);
  check_value({test, " rresp"}, {30'b0, exp_resp}, {30'b0, got_resp});
endtask

/* testbench/tb_axil_split_sys.sv */
`timescale 1ns/1ns

module tb_axil_split_sys;

  import axil_pkg::*;

  localparam int clk_period      = 100;
  localparam int op_budget       = 400;
  localparam int cycles_per_op   = 20;
  localparam int num_order_reads = 40;

  logic     clk      = 1'b0;
  logic     rst      = 1'b1;
  axil_aw_t aw       = '0;
  logic     aw_valid = 1'b0;
  axil_w_t  w        = '0;
  logic     w_valid  = 1'b0;
  logic     b_ready  = 1'b1;
  axil_ar_t ar       = '0;
  logic     ar_valid = 1'b0;
  logic     r_ready  = 1'b1;
  logic     aw_ready;
  logic     w_ready;
  axil_b_t  b;
  logic     b_valid;
  logic     ar_ready;
  axil_r_t  r;
  logic     r_valid;

  // Words already written with a full strobe
  logic [15:0] trunk_known [$];
  logic [15:0] branch_known [$];

  // Expected read responses in request order
  logic [31:0] order_data_q [$];
  logic [1:0]  order_resp_q [$];
  bit          reads_done  = 1'b0;
  bit          writes_done = 1'b0;

  always #(clk_period / 2) clk = ~clk;

  axil_split_sys u_axil_split_sys (.*);

  `include "tb_axil_tasks.svh"

  // --------------------------------------------------------------------------
  // Checking
  // --------------------------------------------------------------------------
  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string test, input logic [31:0] expected,
                                 input logic [31:0] actual);
    stop_run($sformatf("ERROR %s expected %h actual %h", test, expected, actual));
  endtask

  task automatic check_value(input string test, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else report_mismatch(test, expected, actual);
  endtask

  task automatic check_idle(input string test);
    check_value({test, " r_valid"}, 32'd0, {31'b0, r_valid});
    check_value({test, " b_valid"}, 32'd0, {31'b0, b_valid});
    check_value({test, " aw_ready"}, 32'd0, {31'b0, aw_ready});
    check_value({test, " w_ready"}, 32'd0, {31'b0, w_ready});
    check_value({test, " ar_ready"}, 32'd0, {31'b0, ar_ready});
  endtask

  // Two reset edges, then the first free cycle
  task automatic apply_reset();
    @(posedge clk);
    @(posedge clk);
    check_idle("reset asserted");
    rst <= 1'b0;
    @(posedge clk);
    check_idle("reset last cycle");
    @(posedge clk);
    check_idle("after reset");
  endtask

  // --------------------------------------------------------------------------
  // Ordering stress
  // --------------------------------------------------------------------------
  // Pairs on one side, then a switch to the other
  task automatic issue_order_reads();
    logic [15:0] address;
    logic [31:0] sel;
    logic [31:0] exp_data;
    logic [1:0]  exp_resp;
    for (int i = 0; i < num_order_reads; i++) begin
      sel = take_bits(3);
      if (i[1]) begin
        address = 16'h1000 + {11'b0, sel[2:0], 2'b00} + (i[2] ? 16'h1000 : 16'h0000);
      end else begin
        address = 16'h0100 + {11'b0, sel[2:0], 2'b00};
      end
      ar       <= '{addr: address, prot: 3'b000};
      ar_valid <= 1'b1;
      do begin
        @(posedge clk);
      end while (!ar_ready);
      model_read(address, exp_data, exp_resp);
      order_data_q.push_back(exp_data);
      order_resp_q.push_back(exp_resp);
    end
    ar_valid <= 1'b0;
  endtask

  // Checks every cycle that r_valid is up, not only on the transfer
  task automatic collect_order_reads();
    int received;
    received = 0;
    while (received < num_order_reads) begin
      @(posedge clk);
      if (r_valid) begin
        if (order_data_q.size() == 0) begin
          stop_run("A read response appeared with no read outstanding");
        end else begin
          check_value("ordering rdata", order_data_q[0], r.data);
          check_value("ordering rresp", {30'b0, order_resp_q[0]}, {30'b0, r.resp});
          if (r_ready) begin
            void'(order_data_q.pop_front());
            void'(order_resp_q.pop_front());
            received++;
          end
        end
      end
    end
    reads_done = 1'b1;
  endtask

  // Write words are kept apart from the words read above
  task automatic issue_order_writes();
    logic [31:0] bits;
    for (int i = 0; i < 8; i++) begin
      bits = take_bits(32);
      if (i[0]) begin
        do_write("ordering write", 16'h1080 + 16'(4 * i), bits, 4'hf);
      end else begin
        do_write("ordering write", 16'h0200 + 16'(4 * i), bits, 4'hf);
      end
    end
    writes_done = 1'b1;
  endtask

  task automatic drive_backpressure();
    logic [31:0] bits;
    while (!(reads_done && writes_done)) begin
      @(posedge clk);
      bits    = take_bits(2);
      r_ready <= bits[0];
      b_ready <= bits[1];
    end
    r_ready <= 1'b1;
    b_ready <= 1'b1;
  endtask

  initial begin
    #(op_budget * cycles_per_op * clk_period);
    stop_run("Timeout: the test sequence did not finish within its time budget");
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    logic [15:0] address;
    logic [31:0] bits;
    logic [3:0]  strb;
    int          idx;

    apply_reset();

    for (int i = 0; i < 32; i++) begin
      address = trunk_addr();
      bits    = take_bits(32);
      do_write("trunk write", address, bits, 4'hf);
      do_read("trunk readback", address);
      trunk_known.push_back(address);
    end

    // Write through one branch window, read through the other
    bits = take_bits(32);
    do_write("alias trunk write", 16'h0010, bits, 4'hf);
    bits = take_bits(32);
    do_write("alias branch write", 16'h1010, bits, 4'hf);
    do_read("alias branch read", 16'h2010);
    do_read("alias trunk read", 16'h0010);
    trunk_known.push_back(16'h0010);
    branch_known.push_back(16'h1010);

    // Words read later by the ordering stress
    for (int k = 0; k < 8; k++) begin
      bits = take_bits(32);
      do_write("prefill trunk", 16'h0100 + 16'(4 * k), bits, 4'hf);
      trunk_known.push_back(16'h0100 + 16'(4 * k));
      bits = take_bits(32);
      do_write("prefill branch", 16'h1000 + 16'(4 * k), bits, 4'hf);
      branch_known.push_back(16'h1000 + 16'(4 * k));
    end

    for (int i = 0; i < 32; i++) begin
      if (i[0]) begin
        idx     = take_bits(8) % branch_known.size();
        address = branch_known[idx];
        bits    = take_bits(1);
        if (bits[0]) begin
          address = address ^ 16'h3000;
        end
      end else begin
        idx     = take_bits(8) % trunk_known.size();
        address = trunk_known[idx];
      end
      bits = take_bits(4);
      strb = bits[3:0];
      bits = take_bits(32);
      do_write("byte strobe write", address, bits, strb);
      do_read("byte strobe readback", address);
    end

    bits = take_bits(32);
    do_write("decode write", 16'h0800, bits, 4'hf);
    do_read("decode read", 16'h0800);

    reads_done  = 1'b0;
    writes_done = 1'b0;
    fork
      issue_order_reads();
      collect_order_reads();
      issue_order_writes();
      drive_backpressure();
    join
    @(posedge clk);

    // Every request has completed, so no response may be left showing
    if (r_valid || b_valid) begin
      stop_run("A response appeared after every request had completed");
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

/* source/axil_split_sys.sv */
`timescale 1ns/1ns

module axil_split_sys (
  input  logic               clk,
  input  logic               rst,
  input  axil_pkg::axil_aw_t aw,
  input  logic               aw_valid,
  output logic               aw_ready,
  input  axil_pkg::axil_w_t  w,
  input  logic               w_valid,
  output logic               w_ready,
  output axil_pkg::axil_b_t  b,
  output logic               b_valid,
  input  logic               b_ready,
  input  axil_pkg::axil_ar_t ar,
  input  logic               ar_valid,
  output logic               ar_ready,
  output axil_pkg::axil_r_t  r,
  output logic               r_valid,
  input  logic               r_ready
);

  import axil_pkg::*;
  import split_map_pkg::*;

  // Trunk link
  axil_aw_t trunk_aw;
  axil_w_t  trunk_w;
  axil_b_t  trunk_b;
  axil_ar_t trunk_ar;
  axil_r_t  trunk_r;
  logic     trunk_aw_valid, trunk_aw_ready, trunk_w_valid, trunk_w_ready;
  logic     trunk_b_valid, trunk_b_ready, trunk_ar_valid, trunk_ar_ready;
  logic     trunk_r_valid, trunk_r_ready;

  // Branch link
  axil_aw_t branch_aw;
  axil_w_t  branch_w;
  axil_b_t  branch_b;
  axil_ar_t branch_ar;
  axil_r_t  branch_r;
  logic     branch_aw_valid, branch_aw_ready, branch_w_valid, branch_w_ready;
  logic     branch_b_valid, branch_b_ready, branch_ar_valid, branch_ar_ready;
  logic     branch_r_valid, branch_r_ready;

  // Side links connect by matching names
  axil_split u_split (
    .clk,
    .rst,
    .root_aw (aw), .root_aw_valid (aw_valid), .root_aw_ready (aw_ready),
    .root_w  (w),  .root_w_valid  (w_valid),  .root_w_ready  (w_ready),
    .root_b  (b),  .root_b_valid  (b_valid),  .root_b_ready  (b_ready),
    .root_ar (ar), .root_ar_valid (ar_valid), .root_ar_ready (ar_ready),
    .root_r  (r),  .root_r_valid  (r_valid),  .root_r_ready  (r_ready),
    .*
  );

  axil_mem_target #(.words(trunk_words), .index_lsb(2)) u_trunk_mem (
    .clk,
    .rst,
    .aw (trunk_aw), .aw_valid (trunk_aw_valid), .aw_ready (trunk_aw_ready),
    .w  (trunk_w),  .w_valid  (trunk_w_valid),  .w_ready  (trunk_w_ready),
    .b  (trunk_b),  .b_valid  (trunk_b_valid),  .b_ready  (trunk_b_ready),
    .ar (trunk_ar), .ar_valid (trunk_ar_valid), .ar_ready (trunk_ar_ready),
    .r  (trunk_r),  .r_valid  (trunk_r_valid),  .r_ready  (trunk_r_ready),
    .limit_en (1'b1)
  );

  // Both branch windows alias onto this small memory
  axil_mem_target #(.words(branch_words), .index_lsb(2)) u_branch_mem (
    .clk,
    .rst,
    .aw (branch_aw), .aw_valid (branch_aw_valid), .aw_ready (branch_aw_ready),
    .w  (branch_w),  .w_valid  (branch_w_valid),  .w_ready  (branch_w_ready),
    .b  (branch_b),  .b_valid  (branch_b_valid),  .b_ready  (branch_b_ready),
    .ar (branch_ar), .ar_valid (branch_ar_valid), .ar_ready (branch_ar_ready),
    .r  (branch_r),  .r_valid  (branch_r_valid),  .r_ready  (branch_r_ready),
    .limit_en (1'b0)
  );

endmodule

/* source/axil_mem_target.sv */
`timescale 1ns/1ns

module axil_mem_target #(
  parameter int words     = 256,
  parameter int index_lsb = 2
) (
  input  logic               clk,
  input  logic               rst,
  input  axil_pkg::axil_aw_t aw,
  input  logic               aw_valid,
  output logic               aw_ready,
  input  axil_pkg::axil_w_t  w,
  input  logic               w_valid,
  output logic               w_ready,
  output axil_pkg::axil_b_t  b,
  output logic               b_valid,
  input  logic               b_ready,
  input  axil_pkg::axil_ar_t ar,
  input  logic               ar_valid,
  output logic               ar_ready,
  output axil_pkg::axil_r_t  r,
  output logic               r_valid,
  input  logic               r_ready,
  input  logic               limit_en
);

  import axil_pkg::*;
  import split_map_pkg::*;

  localparam int index_width = $clog2(words);

  logic [data_width-1:0]  mem [words];
  logic [index_width-1:0] wr_index;
  logic [index_width-1:0] rd_index;
  logic                   wr_fire;
  logic                   rd_fire;
  logic                   wr_decerr;
  logic                   rd_decerr;

  // Address wraps modulo the memory size
  assign wr_index  = aw.addr[index_lsb +: index_width];
  assign rd_index  = ar.addr[index_lsb +: index_width];
  assign wr_decerr = limit_en && (aw.addr >= trunk_limit);
  assign rd_decerr = limit_en && (ar.addr >= trunk_limit);

  // AW and W only move as a pair, one response held at a time
  assign aw_ready = !b_valid && w_valid;
  assign w_ready  = !b_valid && aw_valid;
  assign wr_fire  = aw_valid && w_valid && !b_valid;
  assign ar_ready = !r_valid;
  assign rd_fire  = ar_valid && ar_ready;

  always_ff @(posedge clk) begin
    if (wr_fire && !wr_decerr) begin
      for (int i = 0; i < strb_width; i++) begin
        if (w.strb[i]) begin
          mem[wr_index][8*i +: 8] <= w.data[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      b_valid <= 1'b0;
      r_valid <= 1'b0;
    end else begin
      if (wr_fire) begin
        b_valid <= 1'b1;
      end else if (b_ready) begin
        b_valid <= 1'b0;
      end
      if (rd_fire) begin
        r_valid <= 1'b1;
      end else if (r_ready) begin
        r_valid <= 1'b0;
      end
    end
  end

  // Response payloads
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      b.resp <= wr_decerr ? resp_decerr : resp_okay;
    end
    if (rd_fire) begin
      r.resp <= rd_decerr ? resp_decerr : resp_okay;
      r.data <= rd_decerr ? '0 : mem[rd_index];
    end
  end

endmodule

/* source/axil_split.sv */
`timescale 1ns/1ns

module axil_split (
  input  logic               clk,
  input  logic               rst,
  // Root target side
  input  axil_pkg::axil_aw_t root_aw,
  input  logic               root_aw_valid,
  output logic               root_aw_ready,
  input  axil_pkg::axil_w_t  root_w,
  input  logic               root_w_valid,
  output logic               root_w_ready,
  output axil_pkg::axil_b_t  root_b,
  output logic               root_b_valid,
  input  logic               root_b_ready,
  input  axil_pkg::axil_ar_t root_ar,
  input  logic               root_ar_valid,
  output logic               root_ar_ready,
  output axil_pkg::axil_r_t  root_r,
  output logic               root_r_valid,
  input  logic               root_r_ready,
  // Trunk initiator side
  output axil_pkg::axil_aw_t trunk_aw,
  output logic               trunk_aw_valid,
  input  logic               trunk_aw_ready,
  output axil_pkg::axil_w_t  trunk_w,
  output logic               trunk_w_valid,
  input  logic               trunk_w_ready,
  input  axil_pkg::axil_b_t  trunk_b,
  input  logic               trunk_b_valid,
  output logic               trunk_b_ready,
  output axil_pkg::axil_ar_t trunk_ar,
  output logic               trunk_ar_valid,
  input  logic               trunk_ar_ready,
  input  axil_pkg::axil_r_t  trunk_r,
  input  logic               trunk_r_valid,
  output logic               trunk_r_ready,
  // Branch initiator side
  output axil_pkg::axil_aw_t branch_aw,
  output logic               branch_aw_valid,
  input  logic               branch_aw_ready,
  output axil_pkg::axil_w_t  branch_w,
  output logic               branch_w_valid,
  input  logic               branch_w_ready,
  input  axil_pkg::axil_b_t  branch_b,
  input  logic               branch_b_valid,
  output logic               branch_b_ready,
  output axil_pkg::axil_ar_t branch_ar,
  output logic               branch_ar_valid,
  input  logic               branch_ar_ready,
  input  axil_pkg::axil_r_t  branch_r,
  input  logic               branch_r_valid,
  output logic               branch_r_ready
);

  import axil_pkg::*;
  import split_map_pkg::*;

  localparam int aw_fr_width = $bits(axil_aw_t) + 1;
  localparam int w_fr_width  = $bits(axil_w_t) + 1;
  localparam int r_bits      = $bits(axil_r_t);
  localparam int b_bits      = $bits(axil_b_t);

  logic     ar_is_branch;
  logic     aw_is_branch;
  logic     rd_empty;
  logic     rd_full;
  logic     wr_empty;
  logic     wr_full;
  logic     last_ar_branch;
  logic     last_aw_branch;
  logic     ar_fire;
  logic     r_fire;
  logic     write_accept;
  logic     b_fire;
  logic     aw_fr_ready;
  logic     w_fr_ready;
  logic     aw_pop_valid;
  logic     aw_pop_ready;
  logic     aw_pop_branch;
  logic     w_pop_valid;
  logic     w_pop_ready;
  logic     w_pop_branch;
  axil_aw_t aw_held;
  axil_w_t  w_held;

  function automatic logic in_branch(input logic [addr_width-1:0] addr);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < num_branch_ranges; i++) begin
      hit |= (addr >= branch_ranges[i].start_addr) && (addr <= branch_ranges[i].end_addr);
    end
    return hit;
  endfunction

  assign ar_is_branch = in_branch(root_ar.addr);
  assign aw_is_branch = in_branch(root_aw.addr);

  // --------------------------------------------------------------------------
  // Read address split
  // --------------------------------------------------------------------------
  // A side switch waits until every pending read has drained
  assign trunk_ar_valid  = root_ar_valid && !ar_is_branch && !rd_full &&
                           (rd_empty || !last_ar_branch);
  assign branch_ar_valid = root_ar_valid && ar_is_branch && !rd_full &&
                           (rd_empty || last_ar_branch);
  assign root_ar_ready   = (trunk_ar_valid && trunk_ar_ready) ||
                           (branch_ar_valid && branch_ar_ready);
  assign trunk_ar        = root_ar;
  assign branch_ar       = root_ar;

  assign ar_fire = root_ar_valid && root_ar_ready;
  assign r_fire  = root_r_valid && root_r_ready;

  outstanding_counter #(.limit(max_out_reads)) u_rd_count (
    .clk,
    .rst,
    .incr  (ar_fire),
    .decr  (r_fire),
    .empty (rd_empty),
    .full  (rd_full)
  );

  // --------------------------------------------------------------------------
  // Write pairing and split
  // --------------------------------------------------------------------------
  assign write_accept = root_aw_valid && root_w_valid && aw_fr_ready && w_fr_ready &&
                        !wr_full && (wr_empty || (last_aw_branch == aw_is_branch));
  assign root_aw_ready = write_accept;
  assign root_w_ready  = write_accept;
  assign b_fire        = root_b_valid && root_b_ready;

  outstanding_counter #(.limit(max_out_writes)) u_wr_count (
    .clk,
    .rst,
    .incr  (write_accept),
    .decr  (b_fire),
    .empty (wr_empty),
    .full  (wr_full)
  );

  // Side of the most recent accepted request per direction
  always_ff @(posedge clk) begin
    if (rst) begin
      last_ar_branch <= 1'b0;
      last_aw_branch <= 1'b0;
    end else begin
      if (ar_fire) begin
        last_ar_branch <= ar_is_branch;
      end
      if (write_accept) begin
        last_aw_branch <= aw_is_branch;
      end
    end
  end

  // Both stages carry the route bit with the payload
  flow_reg_both #(.width(aw_fr_width)) u_aw_flow (
    .clk,
    .rst,
    .push_valid (write_accept),
    .push_ready (aw_fr_ready),
    .push_data  ({root_aw, aw_is_branch}),
    .pop_valid  (aw_pop_valid),
    .pop_ready  (aw_pop_ready),
    .pop_data   ({aw_held, aw_pop_branch})
  );

  flow_reg_both #(.width(w_fr_width)) u_w_flow (
    .clk,
    .rst,
    .push_valid (write_accept),
    .push_ready (w_fr_ready),
    .push_data  ({root_w, aw_is_branch}),
    .pop_valid  (w_pop_valid),
    .pop_ready  (w_pop_ready),
    .pop_data   ({w_held, w_pop_branch})
  );

  assign trunk_aw_valid  = aw_pop_valid && !aw_pop_branch;
  assign branch_aw_valid = aw_pop_valid && aw_pop_branch;
  assign trunk_w_valid   = w_pop_valid && !w_pop_branch;
  assign branch_w_valid  = w_pop_valid && w_pop_branch;
  assign aw_pop_ready    = (trunk_aw_valid && trunk_aw_ready) ||
                           (branch_aw_valid && branch_aw_ready);
  assign w_pop_ready     = (trunk_w_valid && trunk_w_ready) ||
                           (branch_w_valid && branch_w_ready);
  assign trunk_aw        = aw_held;
  assign branch_aw       = aw_held;
  assign trunk_w         = w_held;
  assign branch_w        = w_held;

  // --------------------------------------------------------------------------
  // Response merge
  // --------------------------------------------------------------------------
  assign root_r_valid   = trunk_r_valid || branch_r_valid;
  assign root_r         = axil_r_t'(({r_bits{trunk_r_valid}} & trunk_r) |
                                    ({r_bits{branch_r_valid}} & branch_r));
  assign trunk_r_ready  = root_r_ready;
  assign branch_r_ready = root_r_ready;

  assign root_b_valid   = trunk_b_valid || branch_b_valid;
  assign root_b         = axil_b_t'(({b_bits{trunk_b_valid}} & trunk_b) |
                                    ({b_bits{branch_b_valid}} & branch_b));
  assign trunk_b_ready  = root_b_ready;
  assign branch_b_ready = root_b_ready;

endmodule

/* source/flow_reg_both.sv */
`timescale 1ns/1ns

module flow_reg_both #(
  parameter int width = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             push_valid,
  output logic             push_ready,
  input  logic [width-1:0] push_data,
  output logic             pop_valid,
  input  logic             pop_ready,
  output logic [width-1:0] pop_data
);

  logic [width-1:0] entry [2];
  logic             wr_ptr;
  logic             rd_ptr;
  logic [1:0]       count;
  logic [1:0]       count_next;
  logic             push_fire;
  logic             pop_fire;

  assign push_fire = push_valid && push_ready;
  assign pop_fire  = pop_valid && pop_ready;

  always_comb begin
    count_next = count;
    if (push_fire && !pop_fire) begin
      count_next = count + 2'd1;
    end else if (pop_fire && !push_fire) begin
      count_next = count - 2'd1;
    end
  end

  // --------------------------------------------------------------------------
  // Pointers and registered handshake flags
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      count      <= '0;
      wr_ptr     <= 1'b0;
      rd_ptr     <= 1'b0;
      push_ready <= 1'b0;
      pop_valid  <= 1'b0;
    end else begin
      count      <= count_next;
      push_ready <= (count_next != 2'd2);
      pop_valid  <= (count_next != 2'd0);
      if (push_fire) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop_fire) begin
        rd_ptr <= ~rd_ptr;
      end
    end
  end

  // Two payload slots used as a tiny ring
  always_ff @(posedge clk) begin
    if (push_fire) begin
      entry[wr_ptr] <= push_data;
    end
  end

  assign pop_data = entry[rd_ptr];

endmodule

/* source/outstanding_counter.sv */
`timescale 1ns/1ns

module outstanding_counter #(
  parameter int limit = split_map_pkg::max_out_reads
) (
  input  logic clk,
  input  logic rst,
  input  logic incr,
  input  logic decr,
  output logic empty,
  output logic full
);

  import split_map_pkg::*;

  localparam logic [cnt_width-1:0] limit_count = cnt_width'(limit);

  logic [cnt_width-1:0] count;

  // Holds at the limit and never drops below zero
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (incr && !decr && !full) begin
      count <= count + 1'b1;
    end else if (decr && !incr && !empty) begin
      count <= count - 1'b1;
    end
  end

  assign empty = (count == '0);
  assign full  = (count == limit_count);

endmodule

/* source/split_map_pkg.sv */
package split_map_pkg;

  // Branch windows, both ends inclusive
  localparam int num_branch_ranges = 2;

  typedef struct packed {
    logic [axil_pkg::addr_width-1:0] start_addr;
    logic [axil_pkg::addr_width-1:0] end_addr;
  } addr_range_t;

  localparam addr_range_t branch_ranges [num_branch_ranges] = '{
    '{start_addr: 16'h1000, end_addr: 16'h10ff},
    '{start_addr: 16'h2000, end_addr: 16'h20ff}
  };

  // Target sizes in words
  localparam int trunk_words  = 256;
  localparam int branch_words = 64;

  // First address past the trunk memory
  localparam logic [axil_pkg::addr_width-1:0] trunk_limit = 16'h0400;

  // Transactions in flight per direction
  localparam int max_out_reads  = 2;
  localparam int max_out_writes = 2;
  localparam int cnt_width      = 2;

endpackage

/* source/axil_pkg.sv */
package axil_pkg;

  // --------------------------------------------------------------------------
  // Bus widths
  // --------------------------------------------------------------------------
  localparam int addr_width = 16;
  localparam int data_width = 32;
  localparam int strb_width = data_width / 8;
  localparam int prot_width = 3;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_exokay = 2'b01,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } axil_resp_e;

  // --------------------------------------------------------------------------
  // Channel payloads
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic [prot_width-1:0] prot;
  } axil_aw_t;

  typedef struct packed {
    logic [data_width-1:0] data;
    logic [strb_width-1:0] strb;
  } axil_w_t;

  typedef struct packed {
    axil_resp_e resp;
  } axil_b_t;

  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic [prot_width-1:0] prot;
  } axil_ar_t;

  typedef struct packed {
    logic [data_width-1:0] data;
    axil_resp_e            resp;
  } axil_r_t;

endpackage
